//--- filelist.f
design/fpu_dma_pkg.sv
design/fpu_job_sequencer.sv
design/fpu_dma_ctrl.sv
design/line_mem_ctrl.sv
design/fpu_lane_array.sv
design/fpu_line_buffer.sv
design/fpu_dma_top.sv
test/tb_clock_gen.sv
test/tb_fpu_dma_top.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the FPU DMA testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary -Wno-fatal \
    --top-module tb_fpu_dma_top \
    --Mdir obj_dir \
    -o sim_tb \
    -f filelist.f

./obj_dir/sim_tb | tee sim.log

if grep -q "ALL TESTS PASSED" sim.log; then
    echo "Simulation result: pass"
else
    echo "Simulation result: fail"
    exit 1
fi

//--- test/tb_fpu_dma_top.sv
`timescale 1ns/100ps

module tb_fpu_dma_top
    import fpu_dma_pkg::*;
();

    localparam int          NUM_JOBS    = 6;
    localparam int          CYCLE_LIMIT = 60 * NUM_JOBS;
    localparam int          BUSY_ROW    = 1;
    localparam logic [31:0] SEED        = 32'h2526_d4b5;

    typedef struct packed {
        addr_t       src;
        addr_t       dst;
        line_count_t lines;
        fpu_op_t     op;
        scale_t      scale;
        logic        pattern;
    } job_t;

    // Source, destination, lines, op, scale, lane pattern
    job_t jobs [NUM_JOBS] = '{
        '{32'h0000_1000, 32'h0000_8000, 3'd1, OP_ABS,   8'sd0,   1'b0},
        '{32'h0000_2000, 32'h0000_9000, 3'd4, OP_NEG,   8'sd0,   1'b0},
        '{32'h0000_3000, 32'h0000_A000, 3'd2, OP_SCALE, 8'sd3,   1'b1},
        '{32'h0000_4000, 32'h0000_B000, 3'd3, OP_SCALE, -8'sd5,  1'b1},
        '{32'h0000_5000, 32'h0000_C000, 3'd2, OP_SCALE, 8'sd127, 1'b0},
        '{32'h0000_6040, 32'h0000_D0C0, 3'd3, OP_SCALE, 8'h80,   1'b0}
    };

    // Lane 15 first; pattern 1 sits on the SCALE edge cases
    line_t patterns [2] = '{
        {32'h3F80_0000, 32'hBF80_0000, 32'h4049_0FDB, 32'hC049_0FDB,
         32'h42C8_0000, 32'hC2C8_0000, 32'h3DCC_CCCD, 32'hBDCC_CCCD,
         32'h0000_0000, 32'h8000_0000, 32'h7F80_0000, 32'hFF80_0000,
         32'h7FC0_0000, 32'h0000_0001, 32'h4B00_0000, 32'h3F00_0000},
        {32'h7F00_0000, 32'hFF7F_FFFF, 32'h0080_0000, 32'h8080_0000,
         32'h0100_0000, 32'h8180_0000, 32'h0000_0000, 32'h8000_0000,
         32'h007F_FFFF, 32'h807F_FFFF, 32'h7FC0_0001, 32'hFFC0_0000,
         32'h7F80_0000, 32'hFF80_0000, 32'h3F80_0000, 32'hBE00_0000}
    };

    logic        clk;
    logic        rst_n;
    logic        start;
    addr_t       cmd_src;
    addr_t       cmd_dst;
    line_count_t cmd_lines;
    fpu_op_t     cmd_op;
    scale_t      cmd_scale;
    logic        mem_ack = 1'b0;
    line_t       mem_rdata = '0;
    logic        busy;
    logic        done;
    logic        mem_req;
    logic        mem_we;
    addr_t       mem_addr;
    line_t       mem_wdata;

    // Sparse memory split by writer, plus transaction logs
    line_t src_mem [addr_t];
    line_t dst_mem [addr_t];
    addr_t rd_log [$];
    addr_t wr_addr_log [$];
    line_t wr_data_log [$];

    int errors       = 0;
    int tests_run    = 0;
    int tests_failed = 0;
    int done_count   = 0;
    int cycles       = 0;

    tb_clock_gen i_tb_clock_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    fpu_dma_top i_fpu_dma_top (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (start),
        .cmd_src   (cmd_src),
        .cmd_dst   (cmd_dst),
        .cmd_lines (cmd_lines),
        .cmd_op    (cmd_op),
        .cmd_scale (cmd_scale),
        .mem_ack   (mem_ack),
        .mem_rdata (mem_rdata),
        .busy      (busy),
        .done      (done),
        .mem_req   (mem_req),
        .mem_we    (mem_we),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata)
    );

    function automatic line_t read_line_at(addr_t a);
        if (src_mem.exists(a)) begin
            return src_mem[a];
        end
        return {LANES{a ^ 32'h5A5A_C3C3}};
    endfunction

    // Line i of a job flips the low mantissa bits of every lane
    function automatic line_t source_line(int p, int i);
        line_t l;
        l = patterns[p];
        for (int k = 0; k < LANES; k++) begin
            l[k*32 +: 32] = l[k*32 +: 32] ^ lane_t'(i);
        end
        return l;
    endfunction

    function automatic lane_t expect_lane(lane_t v, fpu_op_t op, scale_t s);
        int exp_new;
        exp_new = int'(v[30:23]) + int'(s);
        case (op)
            OP_ABS: return {1'b0, v[30:0]};
            OP_NEG: return {~v[31], v[30:0]};
            default: begin
                if (v[30:23] == 8'hFF) begin
                    return v;
                end
                // Zero, subnormal and underflow all end as signed zero
                if (v[30:23] == 8'h00 || exp_new < 1) begin
                    return {v[31], 31'b0};
                end
                if (exp_new > 254) begin
                    return {v[31], 8'hFF, 23'b0};
                end
                return {v[31], exp_new[7:0], v[22:0]};
            end
        endcase
    endfunction

    function automatic line_t expect_line(line_t src, fpu_op_t op, scale_t s);
        line_t l;
        for (int k = 0; k < LANES; k++) begin
            l[k*32 +: 32] = expect_lane(src[k*32 +: 32], op, s);
        end
        return l;
    endfunction

    task automatic check_line(line_t got, line_t exp, string what);
        if (got !== exp) begin
            errors++;
            $display("ERROR at %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_lane(lane_t got, lane_t exp, string what);
        if (got !== exp) begin
            errors++;
            $display("ERROR at %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_addr(addr_t got, addr_t exp, string what);
        if (got !== exp) begin
            errors++;
            $display("ERROR at %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_flag(logic got, logic exp, string what);
        if (got !== exp) begin
            errors++;
            $display("ERROR at %0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic report_test(int n, string what, int errors_before);
        tests_run++;
        if (errors == errors_before) begin
            $display("Test %0d: %s ... pass", n, what);
        end else begin
            tests_failed++;
            $display("Test %0d: %s ... fail, %0d errors", n, what, errors - errors_before);
        end
    endtask

    task automatic wait_for_done();
        do begin
            @(negedge clk);
            check_flag(busy, 1'b1, "busy during job");
        end while (!done);
    endtask

    task automatic run_job(int r);
        job_t    job;
        fpu_op_t op;
        int      rd_base;
        int      wr_base;
        int      errors_before;
        line_t   expected;
        line_t   got;
        addr_t   offset;
        job           = jobs[r];
        op            = job.op;
        rd_base       = rd_log.size();
        wr_base       = wr_addr_log.size();
        errors_before = errors;
        @(posedge clk);
        start     <= 1'b1;
        cmd_src   <= job.src;
        cmd_dst   <= job.dst;
        cmd_lines <= job.lines;
        cmd_op    <= job.op;
        cmd_scale <= job.scale;
        @(posedge clk);
        start <= 1'b0;
        if (r == BUSY_ROW) begin
            // Second start in mid job
            repeat (3) @(posedge clk);
            start     <= 1'b1;
            cmd_src   <= 32'h0000_F000;
            cmd_dst   <= 32'h0000_E000;
            cmd_lines <= 3'd4;
            cmd_op    <= OP_ABS;
            @(posedge clk);
            start <= 1'b0;
        end
        wait_for_done();
        if (rd_log.size() - rd_base != int'(job.lines) ||
            wr_addr_log.size() - wr_base != int'(job.lines)) begin
            errors++;
            $display("Test %0d: memory saw %0d reads and %0d writes, expected %0d of each",
                     r + 1, rd_log.size() - rd_base, wr_addr_log.size() - wr_base, job.lines);
        end else begin
            for (int i = 0; i < int'(job.lines); i++) begin
                offset   = addr_t'(i * LINE_BYTES);
                expected = expect_line(source_line(int'(job.pattern), i), job.op, job.scale);
                got      = wr_data_log[wr_base + i];
                check_addr(rd_log[rd_base + i], job.src + offset, "read address");
                check_addr(wr_addr_log[wr_base + i], job.dst + offset, "write address");
                for (int k = 0; k < LANES; k++) begin
                    check_lane(got[k*32 +: 32], expected[k*32 +: 32], "written lane");
                end
                check_line(dst_mem[job.dst + offset], expected, "stored line");
            end
        end
        report_test(r + 1, $sformatf("%s job of %0d lines", op.name(), job.lines), errors_before);
    endtask

    // Line memory with 0 to 5 cycles of ack delay
    initial begin
        int ack_wait;
        ack_wait = $urandom(SEED) % 6;
        forever begin
            @(posedge clk);
            mem_ack <= 1'b0;
            if (rst_n && mem_req && !mem_ack) begin
                if (ack_wait == 0) begin
                    mem_ack <= 1'b1;
                    if (mem_we) begin
                        dst_mem[mem_addr] = mem_wdata;
                        wr_addr_log.push_back(mem_addr);
                        wr_data_log.push_back(mem_wdata);
                    end else begin
                        mem_rdata <= read_line_at(mem_addr);
                        rd_log.push_back(mem_addr);
                    end
                    ack_wait = $urandom % 6;
                end else begin
                    ack_wait--;
                end
            end
        end
    end

    always @(posedge clk) begin
        if (done) begin
            done_count <= done_count + 1;
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    initial begin
        int errors_before;
        int rd_base;
        int wr_base;
        start     = 1'b0;
        cmd_src   = '0;
        cmd_dst   = '0;
        cmd_lines = '0;
        cmd_op    = OP_ABS;
        cmd_scale = '0;
        for (int r = 0; r < NUM_JOBS; r++) begin
            for (int i = 0; i < int'(jobs[r].lines); i++) begin
                src_mem[jobs[r].src + addr_t'(i * LINE_BYTES)] =
                    source_line(int'(jobs[r].pattern), i);
            end
        end

        @(posedge rst_n);
        errors_before = errors;
        repeat (3) begin
            @(negedge clk);
            check_flag(busy, 1'b0, "busy after reset");
            check_flag(done, 1'b0, "done after reset");
            check_flag(mem_req, 1'b0, "mem_req after reset");
        end
        report_test(0, "idle outputs after reset", errors_before);

        for (int r = 0; r < NUM_JOBS; r++) begin
            run_job(r);
        end

        // Zero-length start while idle
        errors_before = errors;
        rd_base       = rd_log.size();
        wr_base       = wr_addr_log.size();
        @(posedge clk);
        start     <= 1'b1;
        cmd_src   <= 32'h0000_1000;
        cmd_dst   <= 32'h0000_8000;
        cmd_lines <= 3'd0;
        @(posedge clk);
        start <= 1'b0;
        repeat (20) begin
            @(negedge clk);
            check_flag(busy, 1'b0, "busy after zero-length start");
            check_flag(done, 1'b0, "done after zero-length start");
            check_flag(mem_req, 1'b0, "mem_req after zero-length start");
        end
        if (rd_log.size() != rd_base || wr_addr_log.size() != wr_base) begin
            errors++;
            $display("Test %0d: memory was accessed after an ignored start", NUM_JOBS + 1);
        end
        if (done_count != NUM_JOBS) begin
            errors++;
            $display("Test %0d: %0d done pulses seen for %0d jobs",
                     NUM_JOBS + 1, done_count, NUM_JOBS);
        end
        report_test(NUM_JOBS + 1, "ignored starts and done count", errors_before);

        $display("Summary: %0d tests, %0d passed, %0d failed, %0d check errors",
                 tests_run, tests_run - tests_failed, tests_failed, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- test/tb_clock_gen.sv
`timescale 1ns/100ps

module tb_clock_gen (
    output logic clk,
    output logic rst_n
);

    // 100 ns period
    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

//--- design/fpu_dma_top.sv
`timescale 1ns/100ps

module fpu_dma_top
    import fpu_dma_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        start,
    input  addr_t       cmd_src,
    input  addr_t       cmd_dst,
    input  line_count_t cmd_lines,
    input  fpu_op_t     cmd_op,
    input  scale_t      cmd_scale,
    input  logic        mem_ack,
    input  line_t       mem_rdata,
    output logic        busy,
    output logic        done,
    output logic        mem_req,
    output logic        mem_we,
    output addr_t       mem_addr,
    output line_t       mem_wdata
);

    // Sequencer to DMA controller
    logic        request;
    logic        rd_wr;
    addr_t       req_address;
    line_count_t request_size;
    logic        request_done;
    fpu_op_t     job_op;
    scale_t      job_scale;
    logic        buffer_clear;

    // DMA controller to memory controller
    dma_op_t     op;
    addr_t       raw_address;
    line_index_t address_offset;
    line_t       bus_write_data;
    logic        tx_done;

    // Read and write paths
    logic        rd_valid;
    line_t       read_line;
    line_index_t read_index;
    logic        lane_valid;
    line_t       lane_line;
    line_index_t lane_index;
    line_index_t line_index;
    line_t       write_line;
    logic        fpu_ready;

    fpu_job_sequencer i_fpu_job_sequencer (
        .clk          (clk),
        .rst_n        (rst_n),
        .start        (start),
        .cmd_src      (cmd_src),
        .cmd_dst      (cmd_dst),
        .cmd_lines    (cmd_lines),
        .cmd_op       (cmd_op),
        .cmd_scale    (cmd_scale),
        .request_done (request_done),
        .request      (request),
        .rd_wr        (rd_wr),
        .address      (req_address),
        .request_size (request_size),
        .job_op       (job_op),
        .job_scale    (job_scale),
        .buffer_clear (buffer_clear),
        .busy         (busy),
        .done         (done)
    );

    fpu_dma_ctrl i_fpu_dma_ctrl (
        .clk                     (clk),
        .rst_n                   (rst_n),
        .request                 (request),
        .rd_wr                   (rd_wr),
        .address                 (req_address),
        .request_size            (request_size),
        .fpu_ready               (fpu_ready),
        .write_line              (write_line),
        .tx_done                 (tx_done),
        .request_done            (request_done),
        .line_index              (line_index),
        .op                      (op),
        .raw_address             (raw_address),
        .address_offset          (address_offset),
        .common_data_bus_read_in (bus_write_data)
    );

    line_mem_ctrl i_line_mem_ctrl (
        .clk                     (clk),
        .rst_n                   (rst_n),
        .op                      (op),
        .raw_address             (raw_address),
        .address_offset          (address_offset),
        .common_data_bus_read_in (bus_write_data),
        .mem_ack                 (mem_ack),
        .mem_rdata               (mem_rdata),
        .tx_done                 (tx_done),
        .rd_valid                (rd_valid),
        .read_line               (read_line),
        .read_index              (read_index),
        .mem_req                 (mem_req),
        .mem_we                  (mem_we),
        .mem_addr                (mem_addr),
        .mem_wdata               (mem_wdata)
    );

    fpu_lane_array i_fpu_lane_array (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (rd_valid),
        .in_line   (read_line),
        .in_index  (read_index),
        .job_op    (job_op),
        .job_scale (job_scale),
        .out_valid (lane_valid),
        .out_line  (lane_line),
        .out_index (lane_index)
    );

    fpu_line_buffer i_fpu_line_buffer (
        .clk       (clk),
        .rst_n     (rst_n),
        .clear     (buffer_clear),
        .wr_valid  (lane_valid),
        .wr_line   (lane_line),
        .wr_index  (lane_index),
        .rd_index  (line_index),
        .rd_line   (write_line),
        .fpu_ready (fpu_ready)
    );

endmodule

//--- design/fpu_line_buffer.sv
`timescale 1ns/100ps

module fpu_line_buffer
    import fpu_dma_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        clear,
    input  logic        wr_valid,
    input  line_t       wr_line,
    input  line_index_t wr_index,
    input  line_index_t rd_index,
    output line_t       rd_line,
    output logic        fpu_ready
);

    line_t                slots [LINES_MAX];
    logic [LINES_MAX-1:0] slot_valid;

    // A new job drops every result of the last one
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            slot_valid <= '0;
        end else begin
            if (clear) begin
                slot_valid <= '0;
            end
            if (wr_valid) begin
                slot_valid[wr_index] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_valid) begin
            slots[wr_index] <= wr_line;
        end
    end

    // Read side is combinational for the write path
    assign rd_line   = slots[rd_index];
    assign fpu_ready = slot_valid[rd_index];

endmodule

//--- design/fpu_lane_array.sv
`timescale 1ns/100ps

module fpu_lane_array
    import fpu_dma_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        in_valid,
    input  line_t       in_line,
    input  line_index_t in_index,
    input  fpu_op_t     job_op,
    input  scale_t      job_scale,
    output logic        out_valid,
    output line_t       out_line,
    output line_index_t out_index
);

    line_t result;

    // Exponent shift with saturation and flush to zero
    function automatic lane_t scale_lane(lane_t value, scale_t scale);
        logic              sign;
        logic [7:0]        exp_in;
        logic signed [9:0] exp_sum;
        begin
            sign    = value[31];
            exp_in  = value[30:23];
            exp_sum = $signed({2'b00, exp_in}) + scale;
            if (exp_in == 8'hFF) begin
                scale_lane = value;
            end else if (exp_in == 8'h00) begin
                // Zero and subnormal inputs
                scale_lane = {sign, 31'b0};
            end else if (exp_sum > 10'sd254) begin
                scale_lane = {sign, 8'hFF, 23'b0};
            end else if (exp_sum < 10'sd1) begin
                scale_lane = {sign, 31'b0};
            end else begin
                scale_lane = {sign, exp_sum[7:0], value[22:0]};
            end
        end
    endfunction

    function automatic lane_t lane_op(lane_t value, fpu_op_t op, scale_t scale);
        case (op)
            OP_ABS:   lane_op = {1'b0, value[30:0]};
            OP_NEG:   lane_op = {~value[31], value[30:0]};
            OP_SCALE: lane_op = scale_lane(value, scale);
            default:  lane_op = value;
        endcase
    endfunction

    always_comb begin
        for (int i = 0; i < LANES; i++) begin
            result[i*LANE_BITS +: LANE_BITS] =
                lane_op(in_line[i*LANE_BITS +: LANE_BITS], job_op, job_scale);
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= in_valid;
        end
    end

    // Slot index rides along with its line
    always_ff @(posedge clk) begin
        if (in_valid) begin
            out_line  <= result;
            out_index <= in_index;
        end
    end

endmodule

//--- design/line_mem_ctrl.sv
`timescale 1ns/100ps

module line_mem_ctrl
    import fpu_dma_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  dma_op_t     op,
    input  addr_t       raw_address,
    input  line_index_t address_offset,
    input  line_t       common_data_bus_read_in,
    input  logic        mem_ack,
    input  line_t       mem_rdata,
    output logic        tx_done,
    output logic        rd_valid,
    output line_t       read_line,
    output line_index_t read_index,
    output logic        mem_req,
    output logic        mem_we,
    output addr_t       mem_addr,
    output line_t       mem_wdata
);

    mem_state_t state;
    logic       launch;

    // Op is only looked at in idle, never while retiring
    assign launch = (state == MEM_IDLE) && (op != DMA_IDLE);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state  <= MEM_IDLE;
            mem_we <= 1'b0;
        end else begin
            case (state)
                MEM_IDLE: begin
                    if (launch) begin
                        state  <= BUSY;
                        mem_we <= (op == DMA_WRITE);
                    end
                end
                BUSY: begin
                    if (mem_ack) begin
                        state <= RETIRE;
                    end
                end
                default: begin
                    state <= MEM_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (launch) begin
            mem_addr   <= raw_address + addr_t'(address_offset) * addr_t'(LINE_BYTES);
            mem_wdata  <= common_data_bus_read_in;
            read_index <= address_offset;
        end
        if ((state == BUSY) && mem_ack && !mem_we) begin
            read_line <= mem_rdata;
        end
    end

    assign mem_req  = (state == BUSY);
    assign tx_done  = (state == RETIRE);
    assign rd_valid = tx_done && !mem_we;

endmodule

//--- design/fpu_dma_ctrl.sv
`timescale 1ns/100ps

module fpu_dma_ctrl
    import fpu_dma_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        request,
    input  logic        rd_wr,
    input  addr_t       address,
    input  line_count_t request_size,
    input  logic        fpu_ready,
    input  line_t       write_line,
    input  logic        tx_done,
    output logic        request_done,
    output line_index_t line_index,
    output dma_op_t     op,
    output addr_t       raw_address,
    output line_index_t address_offset,
    output line_t       common_data_bus_read_in
);

    dma_state_t  state;
    dma_state_t  next_state;
    line_count_t req_count;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= START;
        end else begin
            state <= next_state;
        end
    end

    // One count per finished line transaction
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            req_count <= '0;
        end else if (state != ACTIVE) begin
            req_count <= '0;
        end else if (tx_done) begin
            req_count <= req_count + 1'b1;
        end
    end

    assign line_index = line_index_t'(req_count);

    always_comb begin
        next_state              = state;
        op                      = DMA_IDLE;
        raw_address             = '0;
        address_offset          = '0;
        common_data_bus_read_in = '0;
        request_done            = 1'b0;
        case (state)
            START: begin
                if (request) begin
                    next_state = ACTIVE;
                end
            end
            ACTIVE: begin
                raw_address    = address;
                address_offset = line_index;
                if (req_count == request_size) begin
                    next_state = DONE;
                end else if (!rd_wr) begin
                    op = DMA_READ;
                end else if (fpu_ready) begin
                    // Hold off writes until the lane result has landed
                    op                      = DMA_WRITE;
                    common_data_bus_read_in = write_line;
                end
            end
            DONE: begin
                request_done = 1'b1;
                next_state   = START;
            end
            default: begin
                next_state = START;
            end
        endcase
    end

endmodule

//--- design/fpu_job_sequencer.sv
`timescale 1ns/100ps

module fpu_job_sequencer
    import fpu_dma_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        start,
    input  addr_t       cmd_src,
    input  addr_t       cmd_dst,
    input  line_count_t cmd_lines,
    input  fpu_op_t     cmd_op,
    input  scale_t      cmd_scale,
    input  logic        request_done,
    output logic        request,
    output logic        rd_wr,
    output addr_t       address,
    output line_count_t request_size,
    output fpu_op_t     job_op,
    output scale_t      job_scale,
    output logic        buffer_clear,
    output logic        busy,
    output logic        done
);

    seq_state_t state;
    addr_t      src_addr;
    addr_t      dst_addr;
    logic       accept;

    // Zero-length jobs and starts during a job are dropped
    assign accept = start && (state == IDLE) && (cmd_lines != '0);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE: begin
                    if (accept) begin
                        state <= READ;
                    end
                end
                READ: begin
                    if (request_done) begin
                        state <= WRITE;
                    end
                end
                WRITE: begin
                    if (request_done) begin
                        state <= FINISH;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // Command stays fixed for the whole job
    always_ff @(posedge clk) begin
        if (accept) begin
            src_addr     <= cmd_src;
            dst_addr     <= cmd_dst;
            request_size <= cmd_lines;
            job_op       <= cmd_op;
            job_scale    <= cmd_scale;
        end
    end

    // Request stays up across the read to write change, only rd_wr flips
    assign request      = (state == READ) || (state == WRITE);
    assign rd_wr        = (state == WRITE);
    assign address      = rd_wr ? dst_addr : src_addr;
    assign buffer_clear = accept;
    assign busy         = (state != IDLE);
    assign done         = (state == FINISH);

endmodule

//--- design/fpu_dma_pkg.sv
package fpu_dma_pkg;

    // Bus and line geometry
    localparam int ADDR_BITS  = 32;
    localparam int LINE_BITS  = 512;
    localparam int LANES      = 16;
    localparam int LANE_BITS  = LINE_BITS / LANES;
    localparam int LINE_BYTES = LINE_BITS / 8;

    // Result buffer depth, also the longest job
    localparam int LINES_MAX  = 4;

    typedef logic [ADDR_BITS-1:0]          addr_t;
    typedef logic [LINE_BITS-1:0]          line_t;
    typedef logic [LANE_BITS-1:0]          lane_t;

    // Job length, 1 to LINES_MAX
    typedef logic [2:0]                    line_count_t;
    typedef logic [$clog2(LINES_MAX)-1:0]  line_index_t;

    // Added to the biased exponent of each lane
    typedef logic signed [7:0]             scale_t;

    typedef enum logic [1:0] {
        OP_ABS,
        OP_NEG,
        OP_SCALE
    } fpu_op_t;

    // Codes seen by the memory controller
    typedef enum logic [1:0] {
        DMA_IDLE  = 2'd0,
        DMA_READ  = 2'd1,
        DMA_WRITE = 2'd3
    } dma_op_t;

    typedef enum logic [1:0] {
        START,
        ACTIVE,
        DONE
    } dma_state_t;

    typedef enum logic [1:0] {
        IDLE,
        READ,
        WRITE,
        FINISH
    } seq_state_t;

    // Own idle label, the sequencer already owns IDLE
    typedef enum logic [1:0] {
        MEM_IDLE,
        BUSY,
        RETIRE
    } mem_state_t;

endpackage
